// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_i2cCmdQueue
FILELIST  = build.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== build.f ====
+incdir+common
common/i2cQueuePkg.sv
common/cmdQueueIf.sv
common/i2cBitIf.sv
cmdQueue/cmdQueueTxFifo.sv
cmdQueue/cmdQueueSequencer.sv
logic/i2cBitEngine.sv
logic/i2cCmdQueueTop.sv
tests/i2cCmdQueue_sva.sv
tests/tb_i2cCmdQueue.sv

// ==== cmdQueue/cmdQueueSequencer.sv ====
/*
 * Command word sequencer
 *   Pops one queue word at a time
 *   Issues START, strobed data bytes in lane order, then STOP
 */
`timescale 1ns/100ps

module cmdQueueSequencer
    import i2cQueuePkg::*;
(
    input  logic   WBs_CLK_i,
    input  logic   WBs_RST_i,
    cmdQueueIf.seq q,
    i2cBitIf.seq   b,
    output logic   i2cBusy_o
);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_POP,
        S_ISSUE,
        S_WAIT
    } seqStateE;

    seqStateE    state;
    ctrlByteT    ctrl;
    logic [23:0] dataR;
    logic [2:0]  laneMask;
    logic        doStart;
    logic        doStop;
    logic        anyPending;

    // Lane 3 decode of the head word
    assign ctrl = ctrlByteT'(q.dat[31:24]);

    assign anyPending = doStart | (|laneMask) | doStop;

    // Data lanes of the popped word
    always_ff @(posedge WBs_CLK_i)
    begin
        if (q.pop)
            dataR <= q.dat[23:0];
    end

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            state    <= S_IDLE;
            laneMask <= 3'b000;
            doStart  <= 1'b0;
            doStop   <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (!q.empty)
                        state <= S_POP;
                S_POP:
                begin
                    // A flush may have emptied the queue meanwhile
                    if (q.empty)
                        state <= S_IDLE;
                    else
                    begin
                        doStart  <= q.byteStb[3] & ctrl.start;
                        doStop   <= q.byteStb[3] & ctrl.stop;
                        laneMask <= q.byteStb[2:0];
                        state    <= S_ISSUE;
                    end
                end
                S_ISSUE:
                begin
                    if (!anyPending)
                        state <= S_IDLE;
                    else
                    begin
                        // Retire the operation handed out with go
                        if (doStart)
                            doStart <= 1'b0;
                        else if (laneMask[0])
                            laneMask[0] <= 1'b0;
                        else if (laneMask[1])
                            laneMask[1] <= 1'b0;
                        else if (laneMask[2])
                            laneMask[2] <= 1'b0;
                        else
                            doStop <= 1'b0;
                        state <= S_WAIT;
                    end
                end
                S_WAIT:
                    // NACK is ignored here, the engine keeps the error
                    if (b.done)
                        state <= anyPending ? S_ISSUE : S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // Lowest pending item goes first
    assign b.op = doStart ? BIT_START : ((|laneMask) ? BIT_WRITE : BIT_STOP);
    assign b.wrByte = laneMask[0] ? dataR[7:0] : (laneMask[1] ? dataR[15:8] : dataR[23:16]);
    assign b.go = (state == S_ISSUE) && anyPending;

    assign q.pop     = (state == S_POP) && !q.empty;
    assign i2cBusy_o = (state != S_IDLE);

endmodule

// ==== cmdQueue/cmdQueueTxFifo.sv ====
/*
 * Transmit command queue
 *   Wishbone write acknowledge
 *   Push source select between Wishbone and the auxiliary controller
 *   Inferred queue storage with read and write pointers
 *   Registered level, empty and full flags
 */
`timescale 1ns/100ps
`include "i2cQueue_defines.svh"

module cmdQueueTxFifo
(
    input  logic                     WBs_CLK_i,
    input  logic                     WBs_RST_i,
    input  logic                     WBs_CYC_i,
    input  logic                     WBs_STB_i,
    input  logic                     WBs_WE_i,
    input  logic [3:0]               WBs_BYTE_STB_i,
    input  logic [31:0]              WBs_DAT_i,
    output logic                     WBs_ACK_o,
    input  logic                     txFifoFlush_i,
    input  logic                     auxPush_i,
    input  logic [35:0]              auxDat_i,
    input  logic                     auxBusy_i,
    cmdQueueIf.fifo                  q,
    output logic [`I2CQ_LEVEL_W-1:0] txFifoLevel_o,
    output logic                     txFifoEmpty_o,
    output logic                     txFifoFull_o
);

    localparam int PTR_W = $clog2(`I2CQ_FIFO_DEPTH);
    localparam logic [`I2CQ_LEVEL_W-1:0] LEVEL_TOP = `I2CQ_LEVEL_W'(`I2CQ_FIFO_DEPTH - 1);

    logic             ackNxt;
    logic             pushSel;
    logic [35:0]      pushDat;
    logic             pushOk;
    logic             popOk;
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [35:0]      headWord;
    logic [35:0]      fifoMem [0:`I2CQ_FIFO_DEPTH-1];

    //------------------------------------------------------------
    // Wishbone side
    //------------------------------------------------------------

    // Ack for one cycle, then low for one
    assign ackNxt = WBs_CYC_i & WBs_STB_i & WBs_WE_i & ~WBs_ACK_o;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            WBs_ACK_o <= 1'b0;
        else
            WBs_ACK_o <= ackNxt;
    end

    // Auxiliary controller owns the queue input while busy
    assign pushSel = auxBusy_i ? auxPush_i : ackNxt;
    assign pushDat = auxBusy_i ? auxDat_i : {WBs_BYTE_STB_i, WBs_DAT_i};

    // Full queue still takes a push paired with a pop
    assign popOk  = q.pop & ~txFifoEmpty_o;
    assign pushOk = pushSel & (~txFifoFull_o | popOk);

    //------------------------------------------------------------
    // Storage and pointers
    //------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i)
    begin
        if (pushOk && !txFifoFlush_i)
            fifoMem[wrPtr] <= pushDat;
    end

    assign headWord = fifoMem[rdPtr];

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            txFifoLevel_o <= '0;
            txFifoEmpty_o <= 1'b1;
            txFifoFull_o  <= 1'b0;
        end
        else if (txFifoFlush_i)
        begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            txFifoLevel_o <= '0;
            txFifoEmpty_o <= 1'b1;
            txFifoFull_o  <= 1'b0;
        end
        else
        begin
            if (pushOk)
                wrPtr <= wrPtr + 1'b1;
            if (popOk)
                rdPtr <= rdPtr + 1'b1;
            // Push and pop together hold level and flags
            case ({popOk, pushOk})
                2'b01:
                begin
                    txFifoLevel_o <= txFifoLevel_o + 1'b1;
                    txFifoEmpty_o <= 1'b0;
                    txFifoFull_o  <= (txFifoLevel_o == LEVEL_TOP);
                end
                2'b10:
                begin
                    txFifoLevel_o <= txFifoLevel_o - 1'b1;
                    txFifoEmpty_o <= (txFifoLevel_o == `I2CQ_LEVEL_W'(1));
                    txFifoFull_o  <= 1'b0;
                end
                default:
                begin
                    txFifoLevel_o <= txFifoLevel_o;
                end
            endcase
        end
    end

    // Head reads as zero while nothing is stored
    assign q.dat     = txFifoEmpty_o ? 32'h0 : headWord[31:0];
    assign q.byteStb = txFifoEmpty_o ? 4'h0 : headWord[35:32];
    assign q.empty   = txFifoEmpty_o;

endmodule

// ==== common/cmdQueueIf.sv ====
/*
 * Queue head interface
 *   fifo modport drives the head word, its strobes and empty
 *   seq modport drives the pop strobe
 */
`timescale 1ns/100ps

interface cmdQueueIf;

    // Head word and its byte strobes, zero while empty
    logic [31:0] dat;
    logic [3:0]  byteStb;
    logic        empty;
    // One-cycle pop, only while not empty
    logic        pop;

    modport fifo (output dat, output byteStb, output empty, input pop);

    modport seq (input dat, input byteStb, input empty, output pop);

endinterface

// ==== common/i2cBitIf.sv ====
/*
 * Bit engine operation interface
 *   seq modport drives op, wrByte and go
 *   eng modport drives done and nack
 */
`timescale 1ns/100ps

interface i2cBitIf
    import i2cQueuePkg::*;
;

    // Operation and byte latched on go
    bitOpE       op;
    logic [7:0]  wrByte;
    // One-cycle start pulse, engine idle only
    logic        go;
    // One-cycle end of operation
    logic        done;
    // Slave refused the byte, valid with done
    logic        nack;

    modport seq (output op, output wrByte, output go, input done, input nack);

    modport eng (input op, input wrByte, input go, output done, output nack);

endinterface

// ==== common/i2cQueuePkg.sv ====
/*
 * Types shared by the I2C command queue
 *   bitOpE     operations accepted by the bit engine
 *   ctrlByteT  layout of the lane 3 control byte
 */
package i2cQueuePkg;

    // Operations handed from the sequencer to the bit engine
    typedef enum logic [1:0]
    {
        BIT_START,
        BIT_WRITE,
        BIT_STOP
    } bitOpE;

    //------------------------------------------------------------
    // Control byte carried in byte lane 3 of a queue word
    //------------------------------------------------------------
    typedef struct packed
    {
        // Not decoded
        logic [5:0] rsvd;
        // STOP after the data bytes
        logic       stop;
        // START before the data bytes
        logic       start;
    } ctrlByteT;

endpackage

// ==== common/i2cQueue_defines.svh ====
/*
 * Sizing macros for the I2C command queue
 *   Transmit queue depth
 *   Width of the queue level count
 *   SCL quarter-period divider
 */
`ifndef I2CQ_DEFINES_SVH
`define I2CQ_DEFINES_SVH

// Entries in the transmit queue
`define I2CQ_FIFO_DEPTH 512

// Width of the level count
// Wraps to zero when the queue holds all entries
`define I2CQ_LEVEL_W 9

// System clocks per quarter of an SCL period
`define I2CQ_CLK_DIV 4

`endif

// ==== logic/i2cBitEngine.sv ====
/*
 * I2C bit engine
 *   Quarter-period timing of START, STOP and byte writes
 *   Open-drain SCL and SDA enables
 *   ACK sampling and sticky NACK error
 */
`timescale 1ns/100ps
`include "i2cQueue_defines.svh"

module i2cBitEngine
    import i2cQueuePkg::*;
(
    input  logic  WBs_CLK_i,
    input  logic  WBs_RST_i,
    input  logic  txFifoFlush_i,
    i2cBitIf.eng  b,
    output logic  sclOe_o,
    output logic  sdaOe_o,
    input  logic  sdaIn_i,
    output logic  i2cNackErr_o
);

    localparam int DIV_W = (`I2CQ_CLK_DIV > 1) ? $clog2(`I2CQ_CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`I2CQ_CLK_DIV - 1);

    logic             busyR;
    bitOpE            opR;
    logic [7:0]       shiftR;
    logic [3:0]       bitCnt;
    logic [1:0]       quarter;
    logic [DIV_W-1:0] divCnt;
    logic             ackSample;
    logic             tick;
    logic             ackBit;
    logic             dataLow;
    logic             shiftStep;
    logic             sclLowNxt;
    logic             sdaLowNxt;

    assign tick      = (divCnt == DIV_LAST);
    // Ninth bit time is the ACK slot
    assign ackBit    = (bitCnt == 4'd8);
    assign dataLow   = ackBit ? 1'b0 : ~shiftR[7];
    assign shiftStep = busyR && tick && (quarter == 2'd3) && (opR == BIT_WRITE) && !ackBit;

    //------------------------------------------------------------
    // Line levels per quarter, enable high pulls low
    //------------------------------------------------------------
    always_comb
    begin
        {sclLowNxt, sdaLowNxt} = {sclOe_o, sdaOe_o};
        case (opR)
            // Release SDA, raise SCL, then SDA falls while SCL is high
            BIT_START:
                case (quarter)
                    2'd0:    sdaLowNxt = 1'b0;
                    2'd1:    {sclLowNxt, sdaLowNxt} = 2'b00;
                    2'd2:    {sclLowNxt, sdaLowNxt} = 2'b01;
                    default: {sclLowNxt, sdaLowNxt} = 2'b11;
                endcase
            // SDA changes only while SCL is low
            BIT_WRITE:
                case (quarter)
                    2'd0:    sclLowNxt = 1'b1;
                    2'd1:    {sclLowNxt, sdaLowNxt} = {1'b1, dataLow};
                    default: {sclLowNxt, sdaLowNxt} = {1'b0, dataLow};
                endcase
            // SDA rises while SCL is high
            BIT_STOP:
                case (quarter)
                    2'd0:    sclLowNxt = 1'b1;
                    2'd1:    {sclLowNxt, sdaLowNxt} = 2'b11;
                    2'd2:    {sclLowNxt, sdaLowNxt} = 2'b01;
                    default: {sclLowNxt, sdaLowNxt} = 2'b00;
                endcase
            default:
                {sclLowNxt, sdaLowNxt} = {sclOe_o, sdaOe_o};
        endcase
    end

    // Byte shifter, MSB first
    always_ff @(posedge WBs_CLK_i)
    begin
        if (!busyR && b.go)
            shiftR <= b.wrByte;
        else if (shiftStep)
            shiftR <= {shiftR[6:0], 1'b0};
    end

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            busyR     <= 1'b0;
            opR       <= BIT_START;
            bitCnt    <= 4'd0;
            quarter   <= 2'd0;
            divCnt    <= '0;
            ackSample <= 1'b0;
            b.done    <= 1'b0;
            b.nack    <= 1'b0;
            sclOe_o   <= 1'b0;
            sdaOe_o   <= 1'b0;
        end
        else
        begin
            b.done <= 1'b0;
            b.nack <= 1'b0;
            if (!busyR)
            begin
                if (b.go)
                begin
                    busyR     <= 1'b1;
                    opR       <= b.op;
                    bitCnt    <= 4'd0;
                    quarter   <= 2'd0;
                    divCnt    <= '0;
                    ackSample <= 1'b0;
                end
            end
            else
            begin
                sclOe_o <= sclLowNxt;
                sdaOe_o <= sdaLowNxt;
                if (!tick)
                    divCnt <= divCnt + 1'b1;
                else
                begin
                    divCnt  <= '0;
                    quarter <= quarter + 2'd1;
                    // Slave drives ACK low through the SCL high phase
                    if ((quarter == 2'd2) && (opR == BIT_WRITE) && ackBit)
                        ackSample <= sdaIn_i;
                    if (quarter == 2'd3)
                    begin
                        if ((opR == BIT_WRITE) && !ackBit)
                            bitCnt <= bitCnt + 4'd1;
                        else
                        begin
                            busyR  <= 1'b0;
                            b.done <= 1'b1;
                            b.nack <= (opR == BIT_WRITE) & ackSample;
                        end
                    end
                end
            end
        end
    end

    // Sticky error until flush
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            i2cNackErr_o <= 1'b0;
        else if (txFifoFlush_i)
            i2cNackErr_o <= 1'b0;
        else if (b.done && b.nack)
            i2cNackErr_o <= 1'b1;
    end

endmodule

// ==== logic/i2cCmdQueueTop.sv ====
/*
 * I2C master with command queue, top level
 *   Transmit queue, sequencer and bit engine
 *   Plain Wishbone, I2C and status ports
 */
`timescale 1ns/100ps
`include "i2cQueue_defines.svh"

module i2cCmdQueueTop
(
    input  logic                     WBs_CLK_i,
    input  logic                     WBs_RST_i,
    input  logic                     WBs_CYC_i,
    input  logic                     WBs_STB_i,
    input  logic                     WBs_WE_i,
    input  logic [3:0]               WBs_BYTE_STB_i,
    input  logic [31:0]              WBs_DAT_i,
    output logic                     WBs_ACK_o,
    input  logic                     txFifoFlush_i,
    input  logic                     auxPush_i,
    input  logic [35:0]              auxDat_i,
    input  logic                     auxBusy_i,
    output logic                     sclOe_o,
    output logic                     sdaOe_o,
    input  logic                     sdaIn_i,
    output logic [`I2CQ_LEVEL_W-1:0] txFifoLevel_o,
    output logic                     txFifoEmpty_o,
    output logic                     txFifoFull_o,
    output logic                     i2cBusy_o,
    output logic                     i2cNackErr_o
);

    // Queue head and bit operation links
    cmdQueueIf cmdQ ();
    i2cBitIf   bitBus ();

    cmdQueueTxFifo u_txFifo
    (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .WBs_CYC_i      (WBs_CYC_i),
        .WBs_STB_i      (WBs_STB_i),
        .WBs_WE_i       (WBs_WE_i),
        .WBs_BYTE_STB_i (WBs_BYTE_STB_i),
        .WBs_DAT_i      (WBs_DAT_i),
        .WBs_ACK_o      (WBs_ACK_o),
        .txFifoFlush_i  (txFifoFlush_i),
        .auxPush_i      (auxPush_i),
        .auxDat_i       (auxDat_i),
        .auxBusy_i      (auxBusy_i),
        .q              (cmdQ),
        .txFifoLevel_o  (txFifoLevel_o),
        .txFifoEmpty_o  (txFifoEmpty_o),
        .txFifoFull_o   (txFifoFull_o)
    );

    cmdQueueSequencer u_sequencer
    (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .q         (cmdQ),
        .b         (bitBus),
        .i2cBusy_o (i2cBusy_o)
    );

    i2cBitEngine u_bitEngine
    (
        .WBs_CLK_i     (WBs_CLK_i),
        .WBs_RST_i     (WBs_RST_i),
        .txFifoFlush_i (txFifoFlush_i),
        .b             (bitBus),
        .sclOe_o       (sclOe_o),
        .sdaOe_o       (sdaOe_o),
        .sdaIn_i       (sdaIn_i),
        .i2cNackErr_o  (i2cNackErr_o)
    );

endmodule

// ==== tests/i2cCmdQueue_sva.sv ====
/*
 * Concurrent checks on the transmit queue
 *   Empty and full exclusive
 *   Single-cycle Wishbone acknowledge
 *   Zero level while empty
 *   Pop only after the head showed data
 */
`timescale 1ns/100ps
`include "i2cQueue_defines.svh"

module cmdQueueChecks
(
    input logic                     WBs_CLK_i,
    input logic                     WBs_RST_i,
    input logic                     wbAck_i,
    input logic                     fifoEmpty_i,
    input logic                     fifoFull_i,
    input logic [`I2CQ_LEVEL_W-1:0] fifoLevel_i,
    input logic                     pop_i
);

    // Flags never claim both states
    emptyFullExcl: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        !(fifoEmpty_i && fifoFull_i))
        else $error("Queue reports empty and full together");

    // Ack is followed by a low cycle
    ackSingle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        wbAck_i |=> !wbAck_i)
        else $error("Wishbone acknowledge held for two cycles");

    emptyLevel: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        fifoEmpty_i |-> (fifoLevel_i == '0))
        else $error("Queue empty with a nonzero level");

    // Sequencer pops one cycle after it saw a word at the head
    popGuard: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        pop_i |-> (!fifoEmpty_i && $past(!fifoEmpty_i)))
        else $error("Pop issued on an empty queue or without a word seen first");

endmodule

bind cmdQueueTxFifo cmdQueueChecks queueChecks
(
    .WBs_CLK_i   (WBs_CLK_i),
    .WBs_RST_i   (WBs_RST_i),
    .wbAck_i     (WBs_ACK_o),
    .fifoEmpty_i (txFifoEmpty_o),
    .fifoFull_i  (txFifoFull_o),
    .fifoLevel_i (txFifoLevel_o),
    .pop_i       (q.pop)
);

// ==== tests/tb_i2cCmdQueue.sv ====
/*
 * Testbench for the I2C command queue master
 *   Clock, reset, Wishbone and auxiliary stimulus
 *   I2C slave model with bus monitor
 *   Reference event function and compare process
 *   Cycle timeout
 */
`timescale 1ns/100ps
`include "i2cQueue_defines.svh"

module tb_i2cCmdQueue;

    typedef logic [31:0] eventQT[$];

    // Bus event codes
    // Byte events carry NACK in bit 8
    localparam logic [31:0] EV_BYTE  = 32'h200;
    localparam logic [31:0] EV_START = 32'h400;
    localparam logic [31:0] EV_STOP  = 32'h800;
    localparam logic [7:0]  NACK_BYTE = 8'hA6;
    localparam int BURST_WORDS = 5;
    localparam int RAND_WORDS  = 12;
    localparam int FILL_LIMIT  = 600;
    // Words pushed over the whole run including the fill
    localparam int NUM_WORDS = 1 + BURST_WORDS + RAND_WORDS + 6 + FILL_LIMIT + 1;
    localparam int TIMEOUT_CYCLES = NUM_WORDS * 40 * 4 * `I2CQ_CLK_DIV + 2000;
    localparam logic [35:0] FILL_WORD = {4'hF, 8'h03, 24'h5A_3C_C3};

    logic                     WBs_CLK_i;
    logic                     WBs_RST_i;
    logic                     WBs_CYC_i;
    logic                     WBs_STB_i;
    logic                     WBs_WE_i;
    logic [3:0]               WBs_BYTE_STB_i;
    logic [31:0]              WBs_DAT_i;
    logic                     WBs_ACK_o;
    logic                     txFifoFlush_i;
    logic                     auxPush_i;
    logic [35:0]              auxDat_i;
    logic                     auxBusy_i;
    logic                     sclOe_o;
    logic                     sdaOe_o;
    logic                     sdaIn_i = 1'b1;
    logic [`I2CQ_LEVEL_W-1:0] txFifoLevel_o;
    logic                     txFifoEmpty_o;
    logic                     txFifoFull_o;
    logic                     i2cBusy_o;
    logic                     i2cNackErr_o;

    int          seed = 32'h308b_ed2c;
    int          cycleCnt = 0;
    int          ackCnt = 0;
    int          wrCnt = 0;
    eventQT      expQ;
    eventQT      obsQ;
    // Monitor state as the master drives the lines
    logic        prevScl = 1'b1;
    logic        prevSda = 1'b1;
    logic        sclLine;
    logic        sdaLine;
    logic [7:0]  rxByte = 8'h00;
    int          bitCnt = 0;
    logic        ackPull = 1'b0;
    logic [31:0] actEv;
    logic [31:0] expEv;

    i2cCmdQueueTop dut
    (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .WBs_CYC_i      (WBs_CYC_i),
        .WBs_STB_i      (WBs_STB_i),
        .WBs_WE_i       (WBs_WE_i),
        .WBs_BYTE_STB_i (WBs_BYTE_STB_i),
        .WBs_DAT_i      (WBs_DAT_i),
        .WBs_ACK_o      (WBs_ACK_o),
        .txFifoFlush_i  (txFifoFlush_i),
        .auxPush_i      (auxPush_i),
        .auxDat_i       (auxDat_i),
        .auxBusy_i      (auxBusy_i),
        .sclOe_o        (sclOe_o),
        .sdaOe_o        (sdaOe_o),
        .sdaIn_i        (sdaIn_i),
        .txFifoLevel_o  (txFifoLevel_o),
        .txFifoEmpty_o  (txFifoEmpty_o),
        .txFifoFull_o   (txFifoFull_o),
        .i2cBusy_o      (i2cBusy_o),
        .i2cNackErr_o   (i2cNackErr_o)
    );

    initial
    begin
        WBs_CLK_i = 1'b0;
        forever #4 WBs_CLK_i = ~WBs_CLK_i;
    end

    //------------------------------------------------------------
    // Reporting
    //------------------------------------------------------------
    task automatic failRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkEq(input string name, input logic [31:0] expV, input logic [31:0] actV);
        if (expV !== actV)
            failRun($sformatf("[FAIL] %s expected %0h actual %0h", name, expV, actV));
    endtask

    // Expected events of one word in bus order
    function automatic eventQT expectEvents(input logic [31:0] dat, input logic [3:0] stb);
        eventQT     evs;
        logic [7:0] dataByte;
        int         lane;
        evs = {};
        if (stb[3] && dat[24])
            evs.push_back(EV_START);
        for (lane = 0; lane < 3; lane++)
        begin
            dataByte = dat[lane*8 +: 8];
            if (stb[lane])
                evs.push_back(EV_BYTE | ((dataByte == NACK_BYTE) ? 32'h100 : 32'h0) | dataByte);
        end
        if (stb[3] && dat[25])
            evs.push_back(EV_STOP);
        return evs;
    endfunction

    task automatic queueExpected(input logic [31:0] dat, input logic [3:0] stb);
        eventQT evs;
        evs = expectEvents(dat, stb);
        foreach (evs[k])
            expQ.push_back(evs[k]);
    endtask

    //------------------------------------------------------------
    // Stimulus tasks
    //------------------------------------------------------------
    task automatic wbWrite(input logic [31:0] dat, input logic [3:0] stb);
        @(posedge WBs_CLK_i);
        WBs_CYC_i      <= 1'b1;
        WBs_STB_i      <= 1'b1;
        WBs_WE_i       <= 1'b1;
        WBs_BYTE_STB_i <= stb;
        WBs_DAT_i      <= dat;
        @(negedge WBs_CLK_i);
        while (!WBs_ACK_o)
            @(negedge WBs_CLK_i);
        @(posedge WBs_CLK_i);
        WBs_CYC_i <= 1'b0;
        WBs_STB_i <= 1'b0;
        WBs_WE_i  <= 1'b0;
        wrCnt++;
        checkEq("ack count", wrCnt, ackCnt);
    endtask

    task automatic pushAuxWord(input logic [35:0] word);
        @(posedge WBs_CLK_i);
        auxPush_i <= 1'b1;
        auxDat_i  <= word;
        @(posedge WBs_CLK_i);
        auxPush_i <= 1'b0;
    endtask

    task automatic pulseFlush();
        @(posedge WBs_CLK_i);
        txFifoFlush_i <= 1'b1;
        @(posedge WBs_CLK_i);
        txFifoFlush_i <= 1'b0;
    endtask

    // Wait until the queue drains and every event is compared
    task automatic waitDrain();
        @(negedge WBs_CLK_i);
        while (!(txFifoEmpty_o && !i2cBusy_o && (expQ.size() == 0)))
            @(negedge WBs_CLK_i);
    endtask

    //------------------------------------------------------------
    // Slave model and bus monitor
    //------------------------------------------------------------
    always @(negedge WBs_CLK_i)
    begin
        sclLine = ~sclOe_o;
        sdaLine = ~sdaOe_o;
        if (sclLine && prevScl && prevSda && !sdaLine)
        begin
            obsQ.push_back(EV_START);
            bitCnt = 0;
        end
        else if (sclLine && prevScl && !prevSda && sdaLine)
        begin
            obsQ.push_back(EV_STOP);
            bitCnt = 0;
        end
        else if (sclLine && !prevScl)
        begin
            // Eight data bits and then the ACK slot from the line
            if (bitCnt < 8)
            begin
                rxByte = {rxByte[6:0], sdaLine};
                bitCnt++;
            end
            else
            begin
                obsQ.push_back(EV_BYTE | (sdaIn_i ? 32'h100 : 32'h0) | rxByte);
                bitCnt = 0;
            end
        end
        else if (!sclLine && prevScl)
            ackPull = (bitCnt == 8) && (rxByte != NACK_BYTE);
        prevScl = sclLine;
        prevSda = sdaLine;
    end

    // Open-drain SDA as seen by the master
    always @(posedge WBs_CLK_i)
        sdaIn_i <= ~(sdaOe_o | ackPull);

    always @(negedge WBs_CLK_i)
        if (WBs_ACK_o)
            ackCnt++;

    // Compare monitored events in order
    initial
    begin
        forever
        begin
            @(posedge WBs_CLK_i);
            while (obsQ.size() > 0)
            begin
                actEv = obsQ.pop_front();
                if (expQ.size() == 0)
                    failRun($sformatf("Unexpected bus event %0h with nothing pending", actEv));
                else
                begin
                    expEv = expQ.pop_front();
                    checkEq("bus event", expEv, actEv);
                end
            end
        end
    end

    always @(posedge WBs_CLK_i)
    begin
        cycleCnt++;
        if (cycleCnt > TIMEOUT_CYCLES)
            failRun($sformatf("Timeout after %0d cycles, bus or queue stalled", cycleCnt));
    end

    //------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------
    initial
    begin
        logic [31:0] word;
        logic [31:0] stbRnd;
        logic [`I2CQ_LEVEL_W-1:0] levelHold;
        eventQT fillEvs;
        int fillCnt;
        int fillEvents;
        WBs_RST_i      = 1'b1;
        WBs_CYC_i      = 1'b0;
        WBs_STB_i      = 1'b0;
        WBs_WE_i       = 1'b0;
        WBs_BYTE_STB_i = 4'h0;
        WBs_DAT_i      = 32'h0;
        txFifoFlush_i  = 1'b0;
        auxPush_i      = 1'b0;
        auxDat_i       = 36'h0;
        auxBusy_i      = 1'b0;
        repeat (8) @(posedge WBs_CLK_i);
        WBs_RST_i <= 1'b0;
        @(negedge WBs_CLK_i);
        checkEq("reset ack", 0, WBs_ACK_o);
        checkEq("reset sclOe", 0, sclOe_o);
        checkEq("reset sdaOe", 0, sdaOe_o);
        checkEq("reset busy", 0, i2cBusy_o);
        checkEq("reset nackErr", 0, i2cNackErr_o);
        checkEq("reset empty", 1, txFifoEmpty_o);
        checkEq("reset level", 0, txFifoLevel_o);

        // Burst queued behind one long word
        queueExpected(32'h03_5C_21_C4, 4'hF);
        wbWrite(32'h03_5C_21_C4, 4'hF);
        @(negedge WBs_CLK_i);
        while (!(i2cBusy_o && txFifoEmpty_o))
            @(negedge WBs_CLK_i);
        for (int i = 0; i < BURST_WORDS; i++)
        begin
            word = {8'h03, 8'h10 + 8'(i), 8'h20 + 8'(i), 8'h30 + 8'(i)};
            queueExpected(word, 4'hF);
            wbWrite(word, 4'hF);
        end
        @(negedge WBs_CLK_i);
        checkEq("burst level", BURST_WORDS, txFifoLevel_o);
        checkEq("burst empty", 0, txFifoEmpty_o);
        waitDrain();

        // Random words and strobes without the refused byte
        for (int i = 0; i < RAND_WORDS; i++)
        begin
            word   = $random(seed);
            stbRnd = $random(seed);
            for (int lane = 0; lane < 3; lane++)
                if (word[lane*8 +: 8] == NACK_BYTE)
                    word[lane*8] = ~word[lane*8];
            queueExpected(word, stbRnd[3:0]);
            wbWrite(word, stbRnd[3:0]);
        end
        waitDrain();
        checkEq("random nackErr", 0, i2cNackErr_o);

        // Auxiliary source owns the queue
        @(posedge WBs_CLK_i);
        auxBusy_i <= 1'b1;
        for (int i = 0; i < 3; i++)
        begin
            wbWrite(32'h03_77_66_55 + i, 4'hF);
            @(negedge WBs_CLK_i);
            checkEq("aux wb dropped", 1, txFifoEmpty_o);
        end
        for (int i = 0; i < 3; i++)
        begin
            word = {8'h03, 8'h40 + 8'(i), 8'h81, 8'h18};
            queueExpected(word, 4'hF);
            pushAuxWord({4'hF, word});
        end
        waitDrain();

        // Fill to full with long words while the engine drains slowly
        fillCnt = 0;
        levelHold = '0;
        fillEvs = expectEvents(FILL_WORD[31:0], FILL_WORD[35:32]);
        fillEvents = fillEvs.size();
        while (!txFifoFull_o && (fillCnt < FILL_LIMIT))
        begin
            levelHold = txFifoLevel_o;
            queueExpected(FILL_WORD[31:0], FILL_WORD[35:32]);
            pushAuxWord(FILL_WORD);
            @(negedge WBs_CLK_i);
            fillCnt++;
        end
        // Full rises on the push into the last free entry
        // The level count wraps to zero there
        checkEq("fill full", 1, txFifoFull_o);
        checkEq("fill level before full", `I2CQ_FIFO_DEPTH - 1, levelHold);
        checkEq("full level", 0, txFifoLevel_o);
        pushAuxWord(FILL_WORD);
        @(negedge WBs_CLK_i);
        checkEq("overflow full", 1, txFifoFull_o);
        checkEq("overflow level", 0, txFifoLevel_o);
        pulseFlush();
        @(negedge WBs_CLK_i);
        checkEq("flush empty", 1, txFifoEmpty_o);
        checkEq("flush level", 0, txFifoLevel_o);
        checkEq("flush full", 0, txFifoFull_o);
        // Flushed words never reach the bus
        repeat (`I2CQ_FIFO_DEPTH * fillEvents)
            void'(expQ.pop_back());
        waitDrain();
        @(posedge WBs_CLK_i);
        auxBusy_i <= 1'b0;

        // Refused middle byte with the later byte and STOP still sent
        word = {8'h03, 8'h17, NACK_BYTE, 8'h42};
        queueExpected(word, 4'hF);
        wbWrite(word, 4'hF);
        waitDrain();
        checkEq("nack error", 1, i2cNackErr_o);
        pulseFlush();
        @(negedge WBs_CLK_i);
        checkEq("flush nackErr", 0, i2cNackErr_o);

        // Idle return
        @(negedge WBs_CLK_i);
        checkEq("idle busy", 0, i2cBusy_o);
        checkEq("idle empty", 1, txFifoEmpty_o);
        checkEq("idle sclOe", 0, sclOe_o);
        checkEq("idle sdaOe", 0, sdaOe_o);
        checkEq("idle events left", 0, obsQ.size());
        $display("sim passed");
        $finish;
    end

endmodule
